/* src/mf_sample_pkg.sv */
`default_nettype none

package mf_sample_pkg;

    //////////////////////////////
    // Window geometry

    // One BLE bit at 16 samples per bit
    localparam int window_len = 16;

    // 802.15.4 bit length, taken from the newest half of the window
    localparam int short_len = 8;

    //////////////////////////////
    // Widths

    // ADC sample coming out of the band-pass filter
    localparam int sample_w = 4;

    // 16 products of 5b x 4b stay well inside 14 bits
    localparam int corr_w = 14;

    // Sum of four squared correlation sums
    localparam int energy_w = 2 * corr_w;

    //////////////////////////////
    // Types

    typedef logic signed [sample_w-1:0] sample_t;

    // One complex sample, I in the upper half
    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_sample_t;

    // Entry 0 holds the oldest sample, entry window_len-1 the newest
    typedef iq_sample_t [window_len-1:0] window_t;

    typedef logic signed [corr_w-1:0] corr_sum_t;

    // Squares are never negative, so energy is kept unsigned
    typedef logic [energy_w-1:0] energy_t;

endpackage

`default_nettype wire

/* src/mf_template_pkg.sv */
`default_nettype none

package mf_template_pkg;

    //////////////////////////////
    // Operating mode

    // BLE uses 2 / 2.5 MHz over 16 samples
    // 802.15.4 uses 2 / 3 MHz over 8 samples
    typedef enum logic {
        mode_ble  = 1'b0,
        mode_15_4 = 1'b1
    } mf_mode_t;

    //////////////////////////////
    // Template types

    localparam int coef_w    = 5;
    localparam int table_len = 16;

    // ADC range plus sign
    typedef logic signed [coef_w-1:0] coef_t;

    // Index 0 is the first template sample and lines up with the oldest window entry
    typedef coef_t [0:table_len-1] tone_table_t;

    typedef struct packed {
        tone_table_t cos_tbl;
        tone_table_t sin_tbl;
    } tone_ref_t;

    //////////////////////////////
    // Tone tables at 16 MHz sampling

    // 2 MHz, eight samples per period
    localparam tone_table_t cos_2m = {
        5'sd15,  5'sd11,  5'sd0,  -5'sd11,
        -5'sd15, -5'sd11, 5'sd0,  5'sd11,
        5'sd15,  5'sd11,  5'sd0,  -5'sd11,
        -5'sd15, -5'sd11, 5'sd0,  5'sd11
    };

    localparam tone_table_t sin_2m = {
        5'sd0,   5'sd11,  5'sd15,  5'sd11,
        5'sd0,   -5'sd11, -5'sd15, -5'sd11,
        5'sd0,   5'sd11,  5'sd15,  5'sd11,
        5'sd0,   -5'sd11, -5'sd15, -5'sd11
    };

    // 2.5 MHz, not periodic inside one window
    localparam tone_table_t cos_25m = {
        5'sd15,  5'sd8,   -5'sd6,  -5'sd15,
        -5'sd11, 5'sd3,   5'sd14,  5'sd12,
        5'sd0,   -5'sd12, -5'sd14, -5'sd3,
        5'sd11,  5'sd15,  5'sd6,   -5'sd8
    };

    localparam tone_table_t sin_25m = {
        5'sd0,   5'sd12,  5'sd14,  5'sd3,
        -5'sd11, -5'sd15, -5'sd6,  5'sd8,
        5'sd15,  5'sd8,   -5'sd6,  -5'sd15,
        -5'sd11, 5'sd3,   5'sd14,  5'sd12
    };

    // 3 MHz
    localparam tone_table_t cos_3m = {
        5'sd15,  5'sd6,   -5'sd11, -5'sd14,
        5'sd0,   5'sd14,  5'sd11,  -5'sd6,
        -5'sd15, -5'sd6,  5'sd11,  5'sd14,
        5'sd0,   -5'sd14, -5'sd11, 5'sd6
    };

    localparam tone_table_t sin_3m = {
        5'sd0,   5'sd14,  5'sd11,  -5'sd6,
        -5'sd15, -5'sd6,  5'sd11,  5'sd14,
        5'sd0,   -5'sd14, -5'sd11, 5'sd6,
        5'sd15,  5'sd6,   -5'sd11, -5'sd14
    };

endpackage

`default_nettype wire

/* src/sample_window.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_window
    import mf_sample_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  iq_sample_t sample_in,
    output window_t    window
);

    //////////////////////////////
    // Shift register
    //
    // Newest sample enters at the top entry, the oldest one
    // falls off entry 0. No enable, a sample arrives every clock.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            window <= '0;
        end else begin
            window <= {sample_in, window[window_len-1:1]};
        end
    end

endmodule

`default_nettype wire

/* src/tone_template_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module tone_template_rom
    import mf_sample_pkg::*;
    import mf_template_pkg::*;
(
    input  mf_mode_t  mode,
    output tone_ref_t low_ref,
    output tone_ref_t high_ref
);

    //////////////////////////////
    // Per-entry table selection
    //
    // Low tone is 2 MHz in both modes.
    // High tone depends on the standard.

    always_comb begin
        for (int k = 0; k < window_len; k++) begin
            low_ref.cos_tbl[k] = cos_2m[k];
            low_ref.sin_tbl[k] = sin_2m[k];

            if (mode == mode_15_4) begin
                // 802.15.4 high tone
                high_ref.cos_tbl[k] = cos_3m[k];
                high_ref.sin_tbl[k] = sin_3m[k];
            end else begin
                // BLE high tone
                high_ref.cos_tbl[k] = cos_25m[k];
                high_ref.sin_tbl[k] = sin_25m[k];
            end
        end
    end

endmodule

`default_nettype wire

/* src/tone_correlator.sv */
`timescale 1ns/1ns
`default_nettype none

module tone_correlator
    import mf_sample_pkg::*;
    import mf_template_pkg::*;
(
    input  mf_mode_t  mode,
    input  window_t   window,
    input  tone_ref_t tone_ref,
    output energy_t   energy
);

    window_t   span;
    corr_sum_t i_cos;
    corr_sum_t i_sin;
    corr_sum_t q_cos;
    corr_sum_t q_sin;

    // One multiply-accumulate step, operands sign extended first
    function automatic corr_sum_t mac(corr_sum_t acc, coef_t coef, sample_t samp);
        return acc + corr_sum_t'(coef) * corr_sum_t'(samp);
    endfunction

    // Full width square of a signed sum
    function automatic energy_t square(corr_sum_t sum);
        logic signed [energy_w-1:0] sq;
        sq = sum * sum;
        return energy_t'(sq);
    endfunction

    //////////////////////////////
    // Span alignment
    //
    // 802.15.4 only looks at the newest short_len samples.
    // They move down to entry 0 so template entry k always
    // meets span entry k; the vacated top entries read zero.

    always_comb begin
        if (mode == mode_15_4) begin
            span = window >> (short_len * $bits(iq_sample_t));
        end else begin
            span = window;
        end
    end

    //////////////////////////////
    // Quadrature correlation

    always_comb begin
        i_cos = '0;
        i_sin = '0;
        q_cos = '0;
        q_sin = '0;
        for (int k = 0; k < window_len; k++) begin
            i_cos = mac(i_cos, tone_ref.cos_tbl[k], span[k].i);
            i_sin = mac(i_sin, tone_ref.sin_tbl[k], span[k].i);
            q_cos = mac(q_cos, tone_ref.cos_tbl[k], span[k].q);
            q_sin = mac(q_sin, tone_ref.sin_tbl[k], span[k].q);
        end
    end

    // Phase independent magnitude of the tone
    assign energy = square(i_cos) + square(i_sin) + square(q_cos) + square(q_sin);

endmodule

`default_nettype wire

/* src/fsk_matched_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module fsk_matched_filter
    import mf_sample_pkg::*;
    import mf_template_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  mf_mode_t   mode,
    input  logic       update,
    input  iq_sample_t sample_in,
    output logic       data
);

    window_t   window;
    tone_ref_t low_ref;
    tone_ref_t high_ref;
    energy_t   low_energy;
    energy_t   high_energy;
    logic      decision;

    sample_window sample_window_i (
        .clk       (clk),
        .rst       (rst),
        .sample_in (sample_in),
        .window    (window)
    );

    tone_template_rom tone_template_rom_i (
        .mode     (mode),
        .low_ref  (low_ref),
        .high_ref (high_ref)
    );

    //////////////////////////////
    // One correlator per tone

    tone_correlator low_corr_i (
        .mode     (mode),
        .window   (window),
        .tone_ref (low_ref),
        .energy   (low_energy)
    );

    tone_correlator high_corr_i (
        .mode     (mode),
        .window   (window),
        .tone_ref (high_ref),
        .energy   (high_energy)
    );

    // Ties go to 1, so silence decodes as 1
    assign decision = (low_energy > high_energy) ? 1'b0 : 1'b1;

    //////////////////////////////
    // Data register

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data <= 1'b0;
        end else if (update) begin
            data <= decision;
        end
    end

endmodule

`default_nettype wire

/* testbench/mf_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module mf_assert
    import mf_sample_pkg::*;
    import mf_template_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input mf_mode_t   mode,
    input logic       update,
    input iq_sample_t sample_in,
    input logic       data
);

    // Number of failed assertions
    int fail_count = 0;

    // Data register is cleared while reset is held
    reset_clears_data: assert property (@(posedge clk) !rst |-> !data)
        else begin
            $error("data is not zero while reset is low");
            fail_count = fail_count + 1;
        end

    // Data only moves at an edge that saw update
    data_holds: assert property (@(posedge clk) disable iff (!rst)
        !$past(update) |-> $stable(data))
        else begin
            $error("data changed without an update strobe");
            fail_count = fail_count + 1;
        end

    inputs_known: assert property (@(posedge clk) disable iff (!rst)
        !$isunknown({mode, sample_in}))
        else begin
            $error("mode or sample_in holds an unknown value");
            fail_count = fail_count + 1;
        end

endmodule

`default_nettype wire

/* testbench/mf_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module mf_checker (
    input  logic clk,
    input  logic rst,
    input  logic check,
    input  logic expected,
    input  logic data,
    output int   checks_done,
    output int   pass_count,
    output int   fail_count
);

    logic pending;
    logic pending_exp;

    //////////////////////////////
    // Compare one edge after the request edge

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending     <= 1'b0;
            pending_exp <= 1'b0;
            checks_done <= 0;
            pass_count  <= 0;
            fail_count  <= 0;
        end else begin
            if (pending) begin
                if (data !== pending_exp) begin
                    $display("mismatch at %0t ns: data expected %0b, actual %0b",
                             $time, pending_exp, data);
                    fail_count <= fail_count + 1;
                end else begin
                    pass_count <= pass_count + 1;
                end
                checks_done <= checks_done + 1;
            end
            pending     <= check;
            pending_exp <= expected;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_fsk_matched_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fsk_matched_filter
    import mf_sample_pkg::*;
    import mf_template_pkg::*;
();

    // One line of the stimulus file
    typedef struct packed {
        logic [8*24-1:0] name;
        mf_mode_t        mode;
        int              tone;
        int              count;
        logic            upd;
        logic            exp_bit;
    } test_rec_t;

    logic       clk;
    logic       rst;
    mf_mode_t   mode;
    logic       update;
    iq_sample_t sample_in;
    logic       data;
    logic       check;
    logic       expected;
    int         checks_done;
    int         pass_count;
    int         fail_count;
    int         setup_errors;
    longint     timeout_ns;
    test_rec_t  tests[$];

    fsk_matched_filter fsk_matched_filter_i (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .update    (update),
        .sample_in (sample_in),
        .data      (data)
    );

    bind fsk_matched_filter mf_assert mf_assert_i (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .update    (update),
        .sample_in (sample_in),
        .data      (data)
    );

    mf_checker mf_checker_i (
        .clk         (clk),
        .rst         (rst),
        .check       (check),
        .expected    (expected),
        .data        (data),
        .checks_done (checks_done),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    // 4 ns period
    always #2 clk = ~clk;

    //////////////////////////////
    // Stimulus file

    // Comment lines stop the scan early and are skipped
    task automatic read_tests();
        int               fd;
        int               fields;
        int               mode_v;
        int               tone_v;
        int               count_v;
        int               upd_v;
        int               exp_v;
        logic [8*24-1:0]  name_v;
        logic [8*128-1:0] line;
        test_rec_t        rec;
        fd = $fopen("testbench/mf_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file testbench/mf_input.txt");
            setup_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    fields = $sscanf(line, "%s %d %d %d %d %d",
                                     name_v, mode_v, tone_v, count_v, upd_v, exp_v);
                    if (fields == 6) begin
                        if (mode_v > 1 || count_v < 1 ||
                            !(tone_v inside {0, 20, 25, 30})) begin
                            $display("record %0s has a bad mode, tone or sample count", name_v);
                            setup_errors++;
                        end
                        rec.name    = name_v;
                        rec.mode    = mf_mode_t'(mode_v[0]);
                        rec.tone    = tone_v;
                        rec.count   = count_v;
                        rec.upd     = upd_v[0];
                        rec.exp_bit = exp_v[0];
                        tests.push_back(rec);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Template tone halved to fit the ADC range, I on cosine and Q on sine
    function automatic iq_sample_t tone_sample(int tone, int n);
        tone_ref_t  tbl;
        coef_t      half_i;
        coef_t      half_q;
        iq_sample_t s;
        tbl = '0;
        case (tone)
            20: begin
                tbl.cos_tbl = cos_2m;
                tbl.sin_tbl = sin_2m;
            end
            25: begin
                tbl.cos_tbl = cos_25m;
                tbl.sin_tbl = sin_25m;
            end
            30: begin
                tbl.cos_tbl = cos_3m;
                tbl.sin_tbl = sin_3m;
            end
            default: tbl = '0;
        endcase
        half_i = tbl.cos_tbl[n % table_len] >>> 1;
        half_q = tbl.sin_tbl[n % table_len] >>> 1;
        s.i = half_i[sample_w-1:0];
        s.q = half_q[sample_w-1:0];
        return s;
    endfunction

    //////////////////////////////
    // One record

    task automatic run_test(input test_rec_t t, input int idx);
        int fails_before;
        int target;
        fails_before = fail_count;
        target = checks_done + 1;
        for (int n = 0; n < t.count; n++) begin
            @(posedge clk);
            #1;
            mode = t.mode;
            sample_in = tone_sample(t.tone, n);
        end
        // Last sample enters the window here
        @(posedge clk);
        #1;
        sample_in = '0;
        update = t.upd;
        expected = t.exp_bit;
        check = 1'b1;
        @(posedge clk);
        #1;
        update = 1'b0;
        check = 1'b0;
        while (checks_done < target) begin
            @(posedge clk);
            #1;
        end
        $display("test %0d %0s: %s", idx, t.name, (fail_count == fails_before) ? "ok" : "error");
    endtask

    //////////////////////////////
    // Main sequence

    initial begin
        longint budget;
        int     assert_fails;
        clk = 1'b0;
        rst = 1'b0;
        mode = mode_ble;
        update = 1'b0;
        sample_in = '0;
        check = 1'b0;
        expected = 1'b0;
        setup_errors = 0;
        timeout_ns = 0;
        read_tests();
        if (tests.size() == 0) begin
            $display("no test records found in the stimulus file");
            setup_errors++;
        end
        // Each record gets its samples plus 20 cycles of slack
        budget = 0;
        foreach (tests[k]) begin
            budget += (tests[k].count + 20) * 4;
        end
        timeout_ns = budget;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        foreach (tests[k]) begin
            run_test(tests[k], k);
        end
        assert_fails = fsk_matched_filter_i.mf_assert_i.fail_count;
        $display("%0d tests: %0d passed, %0d failed, %0d assertion failures",
                 tests.size(), pass_count, fail_count, assert_fails);
        if (fail_count == 0 && assert_fails == 0 && setup_errors == 0 &&
            pass_count == tests.size()) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    //////////////////////////////
    // Watchdog

    initial begin
        wait (timeout_ns != 0);
        #(timeout_ns);
        $display("timeout: run did not finish within %0d ns", timeout_ns);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* fsk_matched_filter.f */
src/mf_sample_pkg.sv
src/mf_template_pkg.sv
src/sample_window.sv
src/tone_template_rom.sv
src/tone_correlator.sv
src/fsk_matched_filter.sv
testbench/mf_assert.sv
testbench/mf_checker.sv
testbench/tb_fsk_matched_filter.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_fsk_matched_filter -f fsk_matched_filter.f \
    || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/Vtb_fsk_matched_filter)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q '^Testbench passed$' && exit 0 || exit 1

/* testbench/mf_input.txt */
# name  mode(0 ble, 1 15.4)  tone(100 kHz units, zero is silence)  samples  update  expected
# a record without update expects data to hold its previous value
reset_hold        0   0    4  0  0
ble_silence       0   0   16  1  1
ble_2m            0  20   16  1  0
ble_25m           0  25   16  1  1
ble_2m_long       0  20   48  1  0
ble_25m_long      0  25   32  1  1
ble_2m_again      0  20   16  1  0
ble_25m_hold      0  25   16  0  0
ble_25m_release   0  25   16  1  1
ble_2m_hold       0  20   32  0  1
ble_2m_release    0  20   16  1  0
m15_silence       1   0    8  1  1
m15_3m            1  30    8  1  1
m15_2m            1  20    8  1  0
m15_3m_long       1  30   24  1  1
m15_2m_long       1  20   16  1  0
m15_2m_lead       1  20   16  0  0
m15_3m_tail       1  30    8  1  1
m15_2m_hold       1  20    8  0  1
m15_2m_release    1  20    8  1  0
